// File: design/mul_pkg.sv
/*
 * shared constants for the RV64 multiply coprocessor
 * imported by the register block, multipliers, arbiter and testbench
 */
package mul_pkg;

  // ============================================================
  // widths
  // ============================================================
  localparam int xlen   = 64;         // operand width
  localparam int prod_w = 2*xlen + 2; // 65x65 extended product
  localparam int mplr_w = xlen + 3;   // multiplier plus booth guard bits
  localparam int type_w = 5;
  localparam int num_ch = 2;          // multiply channels
  localparam int ch_w   = $clog2(num_ch);
  localparam int apb_aw = 8;
  localparam int apb_dw = 32;

  // multiply type codes
  localparam logic [type_w-1:0] mul_op_mul    = 5'b01110;
  localparam logic [type_w-1:0] mul_op_mulh   = 5'b10011;
  localparam logic [type_w-1:0] mul_op_mulhsu = 5'b10100;
  localparam logic [type_w-1:0] mul_op_mulhu  = 5'b10101;
  localparam logic [type_w-1:0] mul_op_mulw   = 5'b10110;

  // ============================================================
  // register map, byte offsets inside one 32-byte channel window
  // ============================================================
  localparam logic [apb_aw-1:0] reg_a_lo   = 8'h00;
  localparam logic [apb_aw-1:0] reg_a_hi   = 8'h04;
  localparam logic [apb_aw-1:0] reg_b_lo   = 8'h08;
  localparam logic [apb_aw-1:0] reg_b_hi   = 8'h0C;
  localparam logic [apb_aw-1:0] reg_ctrl   = 8'h10;
  localparam logic [apb_aw-1:0] reg_status = 8'h14;
  localparam logic [apb_aw-1:0] reg_res_lo = 8'h18;
  localparam logic [apb_aw-1:0] reg_res_hi = 8'h1C;

  localparam int ctrl_start_bit  = 8;  // type lives in ctrl[4:0]
  localparam int status_busy_bit = 0;
  localparam int status_done_bit = 1;

  // multiplier FSM encoding
  localparam logic [1:0] st_idle   = 2'd0;
  localparam logic [1:0] st_run    = 2'd1;
  localparam logic [1:0] st_finish = 2'd2;

endpackage

// File: design/booth_recoder.sv
/*
 * radix-4 booth recoder
 * turns one 3-bit multiplier group into a 130-bit partial product
 */
`timescale 1ns/100ps

module booth_recoder import mul_pkg::*; (
  input  logic [prod_w-1:0] multiplicand,
  input  logic [2:0]        code,
  output logic [prod_w-1:0] partial_product
);

  logic [prod_w-1:0] mag;  // 0, B or 2B
  logic              neg;  // negate the magnitude

  always_comb begin
    mag = '0;
    neg = 1'b0;
    case (code)
      3'b001, 3'b010: mag = multiplicand;       // +B
      3'b011: mag = multiplicand << 1;          // +2B
      3'b100: begin                             // -2B
        mag = multiplicand << 1;
        neg = 1'b1;
      end
      3'b101, 3'b110: begin                     // -B
        mag = multiplicand;
        neg = 1'b1;
      end
      default: mag = '0;                        // 000 and 111 add nothing
    endcase
  end

  // two's complement negate by inversion plus one
  assign partial_product = neg ? (~mag + prod_w'(1)) : mag;

endmodule

// File: design/booth_multiplier.sv
/*
 * iterative radix-4 booth multiplier, one partial product per cycle
 * start latches operands, done holds the selected 64-bit slice until ack
 */
`timescale 1ns/100ps

module booth_multiplier import mul_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  input  logic [type_w-1:0] mul_type,
  input  logic [xlen-1:0]   multiplicand,
  input  logic [xlen-1:0]   multiplier,
  output logic              done,
  input  logic              ack,
  output logic [xlen-1:0]   product
);

  logic [1:0]        state_q;
  logic [type_w-1:0] type_q;       // type of the running op
  logic [prod_w-1:0] mcand_q;      // shifted left 2 per step
  logic [mplr_w-1:0] mplr_q;       // shifted right 2 per step
  logic [prod_w-1:0] acc_q;
  logic [prod_w-1:0] pp;
  logic [prod_w-1:0] mcand_ext;
  logic [xlen:0]     mplr_ext;     // 65 bits, sign or zero
  logic              is_w;
  logic              mcand_signed;
  logic              mplr_signed;
  logic              last_step;

  // ============================================================
  // operand extension by type
  // ============================================================
  always_comb begin
    is_w         = (mul_type == mul_op_mulw);
    mcand_signed = !((mul_type == mul_op_mulhu) || is_w);
    mplr_signed  = !((mul_type == mul_op_mulhsu) || (mul_type == mul_op_mulhu) || is_w);
    // mulw only needs the low words
    mcand_ext = {{(prod_w-xlen){mcand_signed & multiplicand[xlen-1]}},
                 is_w ? 32'h0 : multiplicand[xlen-1:32],
                 multiplicand[31:0]};
    mplr_ext  = {mplr_signed & multiplier[xlen-1],
                 is_w ? 32'h0 : multiplier[xlen-1:32],
                 multiplier[31:0]};
  end

  // no nonzero booth digit left once the remaining bits are all sign
  assign last_step = (mplr_q == '0) || (&mplr_q);

  booth_recoder u_recoder (
    .multiplicand    (mcand_q),
    .code            (mplr_q[2:0]),
    .partial_product (pp)
  );

  // ============================================================
  // control FSM
  // ============================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= st_idle;
    end else begin
      case (state_q)
        st_idle:   if (start) state_q <= st_run;
        st_run:    if (last_step) state_q <= st_finish;
        st_finish: if (ack) state_q <= st_idle;
        default:   state_q <= st_idle;
      endcase
    end
  end

  // datapath
  always_ff @(posedge clk) begin
    if (state_q == st_idle && start) begin
      type_q  <= mul_type;
      mcand_q <= mcand_ext;
      mplr_q  <= {mplr_ext[xlen], mplr_ext, 1'b0};  // extra sign plus implicit 0
      acc_q   <= '0;
    end else if (state_q == st_run && !last_step) begin
      acc_q   <= acc_q + pp;
      mcand_q <= mcand_q << 2;
      mplr_q  <= {{2{mplr_q[mplr_w-1]}}, mplr_q[mplr_w-1:2]};  // arithmetic shift
    end
  end

  // result slice
  always_comb begin
    case (type_q)
      mul_op_mulh,
      mul_op_mulhsu,
      mul_op_mulhu: product = acc_q[2*xlen-1:xlen];
      mul_op_mulw:  product = {{32{acc_q[31]}}, acc_q[31:0]};
      default:      product = acc_q[xlen-1:0];  // mul
    endcase
  end

  assign done = (state_q == st_finish);

endmodule

// File: design/result_arbiter.sv
/*
 * round-robin arbiter for the shared result write port
 * the granted channel is acked in the same cycle as its write
 */
`timescale 1ns/100ps

module result_arbiter import mul_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic [num_ch-1:0] req,
  input  logic [xlen-1:0]   data0,
  input  logic [xlen-1:0]   data1,
  output logic [num_ch-1:0] ack,
  output logic              wr_en,
  output logic [ch_w-1:0]   wr_ch,
  output logic [xlen-1:0]   wr_data
);

  logic [ch_w-1:0] last_q;  // last granted channel
  logic [ch_w-1:0] pick;

  // ============================================================
  // grant select
  // ============================================================
  always_comb begin
    if (req[0] && req[1]) begin
      pick = ~last_q;  // contested, the other one wins
    end else if (req[1]) begin
      pick = 1'b1;
    end else begin
      pick = 1'b0;
    end
    wr_en   = |req;
    wr_ch   = pick;
    wr_data = pick ? data1 : data0;
    ack     = '0;
    if (wr_en) ack[pick] = 1'b1;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      last_q <= ch_w'(num_ch - 1);  // channel 0 first after reset
    end else if (wr_en) begin
      last_q <= pick;
    end
  end

endmodule

// File: design/mul_apb_regs.sv
/*
 * APB slave holding operand, control, status and result registers
 * one 32-byte window per channel, no wait states
 */
`timescale 1ns/100ps

module mul_apb_regs import mul_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [apb_aw-1:0] paddr,
  input  logic [apb_dw-1:0] pwdata,
  output logic [apb_dw-1:0] prdata,
  output logic              pready,
  output logic              pslverr,
  output logic [num_ch-1:0] start,
  output logic [type_w-1:0] mul_type0,
  output logic [type_w-1:0] mul_type1,
  output logic [xlen-1:0]   op_a0,
  output logic [xlen-1:0]   op_b0,
  output logic [xlen-1:0]   op_a1,
  output logic [xlen-1:0]   op_b1,
  input  logic              wr_en,
  input  logic [ch_w-1:0]   wr_ch,
  input  logic [xlen-1:0]   wr_data
);

  logic [xlen-1:0]   a_q    [num_ch];
  logic [xlen-1:0]   b_q    [num_ch];
  logic [xlen-1:0]   res_q  [num_ch];
  logic [type_w-1:0] type_q [num_ch];
  logic [num_ch-1:0] busy_q;
  logic [num_ch-1:0] done_q;

  logic              access;
  logic [ch_w-1:0]   ch;          // channel window
  logic [apb_aw-1:0] offs;        // offset inside the window
  logic              mapped;
  logic              start_err;
  logic              wr_acc;      // accepted write
  logic [num_ch-1:0] wr_sel;
  logic [num_ch-1:0] ctrl_go;
  logic [num_ch-1:0] wb_hit;
  logic [apb_dw-1:0] rdata;

  // ============================================================
  // address decode and error
  // ============================================================
  assign access = psel & penable;
  assign ch     = paddr[5 +: ch_w];
  assign offs   = {3'b000, paddr[4:0]};

  always_comb begin
    case (offs)
      reg_a_lo, reg_a_hi, reg_b_lo, reg_b_hi,
      reg_ctrl, reg_status, reg_res_lo, reg_res_hi: mapped = (paddr[apb_aw-1:6] == '0);
      default: mapped = 1'b0;
    endcase
  end

  // start on a running channel is rejected
  assign start_err = pwrite && (offs == reg_ctrl) && pwdata[ctrl_start_bit] && busy_q[ch];
  assign pready    = access;
  assign pslverr   = access & (!mapped | start_err);
  assign wr_acc    = access & pwrite & mapped & !start_err;

  always_comb begin
    for (int i = 0; i < num_ch; i++) begin
      wr_sel[i]  = wr_acc && (ch == ch_w'(i));
      ctrl_go[i] = wr_sel[i] && (offs == reg_ctrl) && pwdata[ctrl_start_bit];
      wb_hit[i]  = wr_en && (wr_ch == ch_w'(i));
    end
  end

  // ============================================================
  // registers
  // ============================================================
  always_ff @(posedge clk) begin
    for (int i = 0; i < num_ch; i++) begin
      if (wr_sel[i]) begin
        case (offs)
          reg_a_lo: a_q[i][31:0]      <= pwdata;
          reg_a_hi: a_q[i][xlen-1:32] <= pwdata;
          reg_b_lo: b_q[i][31:0]      <= pwdata;
          reg_b_hi: b_q[i][xlen-1:32] <= pwdata;
          default: ;
        endcase
      end
      if (wb_hit[i]) res_q[i] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      start  <= '0;
      busy_q <= '0;
      done_q <= '0;
      for (int i = 0; i < num_ch; i++) begin
        type_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < num_ch; i++) begin
        start[i] <= ctrl_go[i];  // one cycle after the access
        if (wr_sel[i] && offs == reg_ctrl) type_q[i] <= pwdata[type_w-1:0];
        if (ctrl_go[i]) begin
          busy_q[i] <= 1'b1;  // set with the pulse so a second start is refused
          done_q[i] <= 1'b0;
        end else if (wb_hit[i]) begin
          busy_q[i] <= 1'b0;
          done_q[i] <= 1'b1;
        end
      end
    end
  end

  // read mux
  always_comb begin
    rdata = '0;
    case (offs)
      reg_a_lo:   rdata = a_q[ch][31:0];
      reg_a_hi:   rdata = a_q[ch][xlen-1:32];
      reg_b_lo:   rdata = b_q[ch][31:0];
      reg_b_hi:   rdata = b_q[ch][xlen-1:32];
      reg_ctrl:   rdata = {{(apb_dw-type_w){1'b0}}, type_q[ch]};
      reg_status: begin
        rdata[status_busy_bit] = busy_q[ch];
        rdata[status_done_bit] = done_q[ch];
      end
      reg_res_lo: rdata = res_q[ch][31:0];
      reg_res_hi: rdata = res_q[ch][xlen-1:32];
      default:    rdata = '0;
    endcase
  end

  assign prdata = (psel && !pwrite && mapped) ? rdata : '0;

  assign op_a0     = a_q[0];
  assign op_b0     = b_q[0];
  assign op_a1     = a_q[1];
  assign op_b1     = b_q[1];
  assign mul_type0 = type_q[0];
  assign mul_type1 = type_q[1];

endmodule

// File: design/mul_copro_top.sv
/*
 * multiply coprocessor top level
 * APB register block, two booth multipliers and the result arbiter
 */
`timescale 1ns/100ps

module mul_copro_top import mul_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [apb_aw-1:0] paddr,
  input  logic [apb_dw-1:0] pwdata,
  output logic [apb_dw-1:0] prdata,
  output logic              pready,
  output logic              pslverr
);

  logic [num_ch-1:0] start;
  logic [type_w-1:0] mul_type0;
  logic [type_w-1:0] mul_type1;
  logic [xlen-1:0]   op_a0;
  logic [xlen-1:0]   op_b0;
  logic [xlen-1:0]   op_a1;
  logic [xlen-1:0]   op_b1;
  logic              done0;
  logic              done1;
  logic [xlen-1:0]   product0;
  logic [xlen-1:0]   product1;
  logic [num_ch-1:0] ack;
  logic              wr_en;
  logic [ch_w-1:0]   wr_ch;
  logic [xlen-1:0]   wr_data;

  mul_apb_regs u_regs (
    .clk       (clk),
    .rst       (rst),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .start     (start),
    .mul_type0 (mul_type0),
    .mul_type1 (mul_type1),
    .op_a0     (op_a0),
    .op_b0     (op_b0),
    .op_a1     (op_a1),
    .op_b1     (op_b1),
    .wr_en     (wr_en),
    .wr_ch     (wr_ch),
    .wr_data   (wr_data)
  );

  // channel 0
  booth_multiplier u_mul0 (
    .clk (clk), .rst (rst), .start (start[0]), .mul_type (mul_type0),
    .multiplicand (op_a0), .multiplier (op_b0),
    .done (done0), .ack (ack[0]), .product (product0)
  );

  // channel 1
  booth_multiplier u_mul1 (
    .clk (clk), .rst (rst), .start (start[1]), .mul_type (mul_type1),
    .multiplicand (op_a1), .multiplier (op_b1),
    .done (done1), .ack (ack[1]), .product (product1)
  );

  result_arbiter u_arb (
    .clk     (clk),
    .rst     (rst),
    .req     ({done1, done0}),
    .data0   (product0),
    .data1   (product1),
    .ack     (ack),
    .wr_en   (wr_en),
    .wr_ch   (wr_ch),
    .wr_data (wr_data)
  );

endmodule

// File: tb/tb_clock_gen.sv
/*
 * testbench clock and reset source
 * 100 ns clock, reset held high for the first 8 rising edges
 */
`timescale 1ns/100ps

module tb_clock_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  initial begin
    rst = 1'b1;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

// File: tb/mul_copro_asserts.sv
/*
 * concurrent protocol checks for the multiply coprocessor
 * bound into mul_copro_top, failures raise $error and bump fail_count
 */
`timescale 1ns/100ps

module mul_copro_asserts import mul_pkg::*; (
  input logic              clk,
  input logic              rst,
  input logic              psel,
  input logic              penable,
  input logic              pready,
  input logic              pslverr,
  input logic [num_ch-1:0] start,
  input logic              done0,
  input logic              done1,
  input logic [num_ch-1:0] ack,
  input logic              wr_en,
  input logic [num_ch-1:0] busy,       // register block busy flags
  input logic [num_ch-1:0] done_flag   // register block done flags
);

  int                fail_count = 0;
  logic [num_ch-1:0] done_out;

  assign done_out = {done1, done0};

  // ============================================================
  // APB slave
  // ============================================================
  pready_in_access: assert property (@(posedge clk) disable iff (rst)
    psel && penable |-> pready)
    else begin
      $error("pready low in an APB access cycle");
      fail_count++;
    end

  pready_needs_psel: assert property (@(posedge clk) disable iff (rst)
    pready |-> psel && penable)
    else begin
      $error("pready high outside an APB access cycle");
      fail_count++;
    end

  slverr_in_access: assert property (@(posedge clk) disable iff (rst)
    pslverr |-> pready)
    else begin
      $error("pslverr high outside an APB access cycle");
      fail_count++;
    end

  // one grant on the shared write port, and only with wr_en
  one_grant: assert property (@(posedge clk) disable iff (rst)
    $onehot0(ack) && (wr_en == (ack != '0)))
    else begin
      $error("result write port granted to more than one channel");
      fail_count++;
    end

  // ============================================================
  // per channel handshake
  // ============================================================
  for (genvar i = 0; i < num_ch; i++) begin : g_ch
    done_acked: assert property (@(posedge clk) disable iff (rst)
      done_out[i] |-> ##[0:1] ack[i])
      else begin
        $error("channel %0d done was not acked in time", i);
        fail_count++;
      end

    done_held: assert property (@(posedge clk) disable iff (rst)
      done_out[i] && !ack[i] |=> done_out[i])
      else begin
        $error("channel %0d dropped done before ack", i);
        fail_count++;
      end

    start_idle: assert property (@(posedge clk) disable iff (rst)
      start[i] |-> !$past(busy[i]))
      else begin
        $error("channel %0d started while busy", i);
        fail_count++;
      end

    done_after_busy: assert property (@(posedge clk) disable iff (rst)
      $rose(done_flag[i]) |-> $past(busy[i]))
      else begin
        $error("channel %0d done set without a running op", i);
        fail_count++;
      end
  end

endmodule

// File: tb/mul_copro_tb.sv
/*
 * testbench for the multiply coprocessor over APB
 * directed corner, random, contention and error cases on both channels
 */
`timescale 1ns/100ps

module mul_copro_tb import mul_pkg::*;;

  localparam int test_count      = 40;
  localparam int cycles_per_test = 60;
  localparam int max_cycles      = test_count * cycles_per_test + 600;  // extra tests, reset

  logic        clk;
  logic        rst;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  int          errors = 0;
  int          cycles = 0;
  integer      seed = 32'ha5d79077;
  int          ch_sel = 0;
  logic        err;
  logic [31:0] rd;
  logic [63:0] a;
  logic [63:0] b;
  logic [4:0]  ops [5] = '{mul_op_mul, mul_op_mulh, mul_op_mulhsu, mul_op_mulhu, mul_op_mulw};
  logic [63:0] corners [5] = '{64'h0, 64'h1, 64'hFFFF_FFFF_FFFF_FFFF,
                               64'h8000_0000_0000_0000, 64'h7FFF_FFFF_FFFF_FFFF};

  tb_clock_gen u_clock_gen (
    .clk (clk),
    .rst (rst)
  );

  mul_copro_top mul_copro_top_inst (
    .clk     (clk),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  bind mul_copro_top mul_copro_asserts u_asserts (
    .clk (clk), .rst (rst), .psel (psel), .penable (penable),
    .pready (pready), .pslverr (pslverr), .start (start),
    .done0 (done0), .done1 (done1), .ack (ack), .wr_en (wr_en),
    .busy (u_regs.busy_q), .done_flag (u_regs.done_q)
  );

  // ============================================================
  // APB transfers, setup then access then one idle cycle
  // ============================================================
  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic slverr);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    slverr = pslverr;  // access cycle, stable
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic slverr);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    data   = prdata;
    slverr = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  // reference product, full 128 bits from the extended operands
  function automatic logic [63:0] expected_result(input logic [4:0] op,
                                                  input logic [63:0] x, input logic [63:0] y);
    logic [127:0] ex;
    logic [127:0] ey;
    logic [127:0] p;
    logic         x_signed;
    logic         y_signed;
    x_signed = (op == mul_op_mulh) || (op == mul_op_mulhsu);
    y_signed = (op == mul_op_mulh);
    ex = x_signed ? {{64{x[63]}}, x} : {64'h0, x};
    ey = y_signed ? {{64{y[63]}}, y} : {64'h0, y};
    p  = ex * ey;
    case (op)
      mul_op_mulh, mul_op_mulhsu, mul_op_mulhu: return p[127:64];
      mul_op_mulw: return {{32{p[31]}}, p[31:0]};
      default:     return p[63:0];
    endcase
  endfunction

  task automatic load_operands(input logic [7:0] base, input logic [63:0] x, input logic [63:0] y);
    logic e;
    apb_write(base + reg_a_lo, x[31:0], e);
    check_val("pslverr", e, 0);
    apb_write(base + reg_a_hi, x[63:32], e);
    check_val("pslverr", e, 0);
    apb_write(base + reg_b_lo, y[31:0], e);
    check_val("pslverr", e, 0);
    apb_write(base + reg_b_hi, y[63:32], e);
    check_val("pslverr", e, 0);
  endtask

  task automatic start_channel(input logic [7:0] base, input logic [4:0] op, output logic slverr);
    apb_write(base + reg_ctrl, (32'h1 << ctrl_start_bit) | 32'(op), slverr);
  endtask

  // poll status until done, then done alone must be set
  task automatic wait_done(input logic [7:0] base);
    logic [31:0] st;
    logic        e;
    st = '0;
    while (!st[status_done_bit]) apb_read(base + reg_status, st, e);
    check_val("status", st, 32'h1 << status_done_bit);
  endtask

  task automatic check_result(input logic [7:0] base, input logic [63:0] exp);
    logic [31:0] lo;
    logic [31:0] hi;
    logic        e;
    apb_read(base + reg_res_lo, lo, e);
    apb_read(base + reg_res_hi, hi, e);
    check_val(base[5] ? "result_ch1" : "result_ch0", {hi, lo}, exp);
  endtask

  task automatic run_mul(input int ch, input logic [4:0] op, input logic [63:0] x,
                         input logic [63:0] y);
    logic [7:0]  base;
    logic [31:0] st;
    logic        e;
    base = (ch != 0) ? 8'h20 : 8'h00;
    load_operands(base, x, y);
    start_channel(base, op, e);
    check_val("pslverr", e, 0);
    apb_read(base + reg_status, st, e);
    check_val("status", st, 32'h1 << status_busy_bit);  // busy, old done cleared
    wait_done(base);
    check_result(base, expected_result(op, x, y));
  endtask

  // ============================================================
  // stimulus
  // ============================================================
  initial begin
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    while (rst !== 1'b0) @(posedge clk);

    for (int c = 0; c < num_ch; c++) begin
      apb_read(8'(c * 32) + reg_status, rd, err);
      check_val("status", rd, 0);
    end

    // restart while busy is refused and leaves the running op alone
    a = {$random(seed), $random(seed)};
    b = 64'h5555_5555_5555_5555;
    load_operands(8'h00, a, b);
    start_channel(8'h00, mul_op_mulh, err);
    start_channel(8'h00, mul_op_mulhu, err);
    check_val("pslverr", err, 1);
    apb_read(reg_ctrl, rd, err);
    check_val("ctrl", rd, 32'(mul_op_mulh));
    apb_read(8'h40, rd, err);  // outside both windows
    check_val("pslverr", err, 1);
    apb_write(8'h23, 32'h0, err);
    check_val("pslverr", err, 1);
    wait_done(8'h00);
    check_result(8'h00, expected_result(mul_op_mulh, a, b));

    // both channels back to back, finishing 0, 1 and 2 cycles apart
    for (int d = 0; d < 3; d++) begin
      a = corners[3] + 64'(d);         // new result on every pass
      b = (64'h1 << (2 * d + 1)) - 1;  // 1, 2 or 3 booth steps
      load_operands(8'h00, corners[4] - 64'(d), 64'h7F);
      load_operands(8'h20, a, b);
      start_channel(8'h00, mul_op_mul, err);
      check_val("pslverr", err, 0);
      start_channel(8'h20, mul_op_mul, err);
      check_val("pslverr", err, 0);
      wait_done(8'h00);
      wait_done(8'h20);
      check_result(8'h00, expected_result(mul_op_mul, corners[4] - 64'(d), 64'h7F));
      check_result(8'h20, expected_result(mul_op_mul, a, b));
    end

    for (int t = 0; t < 5; t++) begin
      for (int i = 0; i < 4; i++) begin
        run_mul(ch_sel, ops[t], corners[(t + i) % 5], corners[(2 * i + 3) % 5]);
        ch_sel = 1 - ch_sel;
      end
      for (int i = 0; i < 4; i++) begin
        a = {$random(seed), $random(seed)};
        b = {$random(seed), $random(seed)};
        run_mul(ch_sel, ops[t], a, b);
        ch_sel = 1 - ch_sel;
      end
    end

    repeat (4) @(posedge clk);
    $display("errors: %0d data, %0d protocol", errors, mul_copro_top_inst.u_asserts.fail_count);
    if (errors == 0 && mul_copro_top_inst.u_asserts.fail_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // run limit
  always @(posedge clk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("timeout: run did not finish within %0d cycles", max_cycles);
      $display("test failed");
      $finish;
    end
  end

endmodule

// File: compile.f
design/mul_pkg.sv
design/booth_recoder.sv
design/booth_multiplier.sv
design/result_arbiter.sv
design/mul_apb_regs.sv
design/mul_copro_top.sv
tb/tb_clock_gen.sv
tb/mul_copro_asserts.sv
tb/mul_copro_tb.sv

// File: Bender.yml
package:
  name: mul_copro

sources:
  - design/mul_pkg.sv
  - design/booth_recoder.sv
  - design/booth_multiplier.sv
  - design/result_arbiter.sv
  - design/mul_apb_regs.sv
  - design/mul_copro_top.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/mul_copro_asserts.sv
      - tb/mul_copro_tb.sv
